//--- source/soc_params.svh
// soc address map and timing constants

`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// address map, each window ends at its last byte address
`define SOC_RAM_LAST        32'd8000   // top of ram window
`define SOC_CLINT_LAST      32'd8048   // top of clint window, 12 words
`define SOC_UART_LAST       32'd8096   // top of uart window, 12 words

// clint registers
`define SOC_MTIME_ADDR      32'd8004   // mtime low, high at +4
`define SOC_MTIMECMP_ADDR   32'd8012   // mtimecmp low, high at +4
`define SOC_MSIP_ADDR       32'd8020   // software irq bit 0

// uart registers
`define SOC_UART_DATA_ADDR  32'd8052   // tx byte, write starts frame
`define SOC_UART_BUSY_ADDR  32'd8056   // busy flag in bit 0

// timing, shortened for simulation
`define SOC_TICK_CYCLES     20         // clocks per mtime step, minus one
`define SOC_UART_DVSR       2          // clocks per 1/16 bit

// storage
`define SOC_RAM_BYTES       8192       // ram size in bytes

`endif

//--- source/soc_pkg.sv
// soc bus types

package soc_pkg;

    // one bus word, used for address and data
    typedef logic [31:0] word_t;

    // byte enables, bit n covers bits 8n+7..8n
    typedef logic [3:0] bmask_t;

    // device owning an address
    typedef enum logic [1:0] {
        sel_ram   = 2'd0,  // data ram
        sel_clint = 2'd1,  // timer and soft irq
        sel_uart  = 2'd2,  // transmit uart
        sel_none  = 2'd3   // unmapped, no ack
    } dev_sel_t;

endpackage

//--- source/bus_decoder.sv
// data bus address decoder

`timescale 1ns/1ps
`include "soc_params.svh"

module bus_decoder (
    input  soc_pkg::word_t i_addr,         // master address, held through ack
    input  logic           i_stb,          // one-cycle request
    input  soc_pkg::word_t i_ram_rdata,
    input  soc_pkg::word_t i_clint_rdata,
    input  soc_pkg::word_t i_uart_rdata,
    input  logic           i_ram_ack,
    input  logic           i_clint_ack,
    input  logic           i_uart_ack,
    output logic           o_ram_stb,      // steered strobes
    output logic           o_clint_stb,
    output logic           o_uart_stb,
    output soc_pkg::word_t o_rdata,        // read data back to master
    output logic           o_ack           // ack back to master
);
    import soc_pkg::*;

    dev_sel_t sel;  // owner of current address

    // the only place address ranges are compared
    always_comb begin
        if (i_addr <= `SOC_RAM_LAST) begin
            sel = sel_ram;
        end else if (i_addr <= `SOC_CLINT_LAST) begin
            sel = sel_clint;
        end else if (i_addr <= `SOC_UART_LAST) begin
            sel = sel_uart;
        end else begin
            sel = sel_none;  // old i2c window and above
        end
    end

    // strobe goes to one device at most
    assign o_ram_stb   = i_stb && (sel == sel_ram);
    assign o_clint_stb = i_stb && (sel == sel_clint);
    assign o_uart_stb  = i_stb && (sel == sel_uart);

    // return path, address still stable in ack cycle
    always_comb begin
        case (sel)
            sel_ram: begin
                o_rdata = i_ram_rdata;
                o_ack   = i_ram_ack;
            end
            sel_clint: begin
                o_rdata = i_clint_rdata;
                o_ack   = i_clint_ack;
            end
            sel_uart: begin
                o_rdata = i_uart_rdata;
                o_ack   = i_uart_ack;
            end
            default: begin
                o_rdata = '0;  // unmapped reads zero
                o_ack   = 1'b0;  // and never acks
            end
        endcase
    end

endmodule

//--- source/data_ram.sv
// byte-maskable data ram

`timescale 1ns/1ps
`include "soc_params.svh"

module data_ram (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            i_stb,      // request, one cycle
    input  logic            i_wr_en,    // 1 write, 0 read
    input  soc_pkg::word_t  i_addr,     // byte address
    input  soc_pkg::word_t  i_wdata,
    input  soc_pkg::bmask_t i_wr_mask,  // byte enables
    output soc_pkg::word_t  o_rdata,    // valid with ack
    output logic            o_ack
);
    import soc_pkg::*;

    localparam int WORDS  = `SOC_RAM_BYTES / 4;
    localparam int WORD_W = $clog2(WORDS);

    word_t             mem [WORDS];  // block ram storage
    logic [WORD_W-1:0] idx;          // word index

    assign idx = i_addr[WORD_W+1:2];  // drop byte offset

    // masked write on the strobe edge
    always_ff @(posedge clk) begin
        if (i_stb && i_wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (i_wr_mask[b]) begin
                    mem[idx][8*b +: 8] <= i_wdata[8*b +: 8];  // only enabled lanes
                end
            end
        end
    end

    // registered read, keeps bram inference
    always_ff @(posedge clk) begin
        if (i_stb && !i_wr_en) begin
            o_rdata <= mem[idx];
        end
    end

    // ack one cycle after strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= i_stb;
        end
    end

endmodule

//--- source/clint_timer.sv
// core-local timer and software interrupt

`timescale 1ns/1ps
`include "soc_params.svh"

module clint_timer (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           i_stb,        // request, one cycle
    input  logic           i_wr_en,      // 1 write, 0 read
    input  soc_pkg::word_t i_addr,
    input  soc_pkg::word_t i_wdata,
    output soc_pkg::word_t o_rdata,      // valid with ack
    output logic           o_ack,
    output logic           o_timer_irq,  // mtime >= mtimecmp
    output logic           o_soft_irq    // msip bit
);
    localparam int          TICK_W      = $clog2(`SOC_TICK_CYCLES + 1);
    localparam logic [31:0] MTIME_HI    = `SOC_MTIME_ADDR + 32'd4;
    localparam logic [31:0] MTIMECMP_HI = `SOC_MTIMECMP_ADDR + 32'd4;

    logic [TICK_W-1:0] presc_q;     // prescaler count
    logic              tick;        // mtime step strobe
    logic [63:0]       mtime_q;
    logic [63:0]       mtimecmp_q;
    logic              msip_q;
    logic              wr_stb;
    logic              rd_stb;
    logic              mtime_wr;    // write to either mtime half

    assign wr_stb   = i_stb && i_wr_en;
    assign rd_stb   = i_stb && !i_wr_en;
    assign mtime_wr = wr_stb && (i_addr == `SOC_MTIME_ADDR || i_addr == MTIME_HI);
    assign tick     = (presc_q == TICK_W'(`SOC_TICK_CYCLES));  // wraps every N+1 clocks

    // millisecond-style prescaler
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc_q <= '0;
        end else if (tick) begin
            presc_q <= '0;
        end else begin
            presc_q <= presc_q + 1'b1;
        end
    end

    // mtime, bus write wins over the tick
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime_q <= '0;
        end else if (mtime_wr) begin
            if (i_addr == `SOC_MTIME_ADDR) begin
                mtime_q[31:0] <= i_wdata;
            end else begin
                mtime_q[63:32] <= i_wdata;
            end
        end else if (tick) begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    // compare and msip registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp_q <= '1;  // all ones keeps irq quiet
            msip_q     <= 1'b0;
        end else if (wr_stb) begin
            if (i_addr == `SOC_MTIMECMP_ADDR) mtimecmp_q[31:0] <= i_wdata;
            if (i_addr == MTIMECMP_HI) mtimecmp_q[63:32] <= i_wdata;
            if (i_addr == `SOC_MSIP_ADDR) msip_q <= i_wdata[0];  // upper bits dropped
        end
    end

    // read mux, registered for the ack cycle
    always_ff @(posedge clk) begin
        if (rd_stb) begin
            case (i_addr)
                `SOC_MTIME_ADDR:    o_rdata <= mtime_q[31:0];
                MTIME_HI:           o_rdata <= mtime_q[63:32];
                `SOC_MTIMECMP_ADDR: o_rdata <= mtimecmp_q[31:0];
                MTIMECMP_HI:        o_rdata <= mtimecmp_q[63:32];
                `SOC_MSIP_ADDR:     o_rdata <= {31'd0, msip_q};
                default:            o_rdata <= '0;  // hole in window
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= i_stb;  // strobe to ack, one cycle
        end
    end

    assign o_timer_irq = (mtime_q >= mtimecmp_q);  // unsigned compare
    assign o_soft_irq  = msip_q;

endmodule

//--- source/uart_tx.sv
// transmit-only uart

`timescale 1ns/1ps
`include "soc_params.svh"

module uart_tx (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           i_stb,    // request, one cycle
    input  logic           i_wr_en,  // 1 write, 0 read
    input  soc_pkg::word_t i_addr,
    input  soc_pkg::word_t i_wdata,  // byte in [7:0]
    output soc_pkg::word_t o_rdata,  // busy flag on read
    output logic           o_ack,
    output logic           o_tx      // serial line, idles high
);
    localparam int DIV_W = $clog2(`SOC_UART_DVSR + 1);

    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_start = 2'd1,
        st_data  = 2'd2,
        st_stop  = 2'd3
    } tx_state_t;

    logic [DIV_W-1:0] div_q;               // baud divider
    logic             s_tick;              // 16x bit rate
    tx_state_t        state_q, state_nxt;
    logic [3:0]       s_q, s_nxt;          // ticks inside a bit
    logic [2:0]       n_q, n_nxt;          // data bit index
    logic [7:0]       din_q, din_nxt;      // shift register
    logic             tx_q, tx_nxt;
    logic             busy;
    logic             wr_data;             // write to data address

    assign s_tick  = (div_q == DIV_W'(`SOC_UART_DVSR - 1));
    assign busy    = (state_q != st_idle);
    assign wr_data = i_stb && i_wr_en && (i_addr == `SOC_UART_DATA_ADDR);
    assign o_tx    = tx_q;

    // free-running divider, phase not tied to frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_q <= '0;
        end else if (s_tick) begin
            div_q <= '0;
        end else begin
            div_q <= div_q + 1'b1;
        end
    end

    // fsm next state
    always_comb begin
        state_nxt = state_q;
        s_nxt     = s_q;
        n_nxt     = n_q;
        din_nxt   = din_q;
        tx_nxt    = tx_q;
        case (state_q)
            st_idle: begin
                tx_nxt = 1'b1;
                if (wr_data) begin  // write while busy falls through
                    din_nxt   = i_wdata[7:0];
                    s_nxt     = '0;
                    state_nxt = st_start;
                end
            end
            st_start: begin
                tx_nxt = 1'b0;  // start bit
                if (s_tick) begin
                    if (s_q == 4'd15) begin
                        s_nxt     = '0;
                        n_nxt     = '0;
                        state_nxt = st_data;
                    end else begin
                        s_nxt = s_q + 4'd1;
                    end
                end
            end
            st_data: begin
                tx_nxt = din_q[0];  // lsb first
                if (s_tick) begin
                    if (s_q == 4'd15) begin
                        s_nxt   = '0;
                        din_nxt = din_q >> 1;
                        if (n_q == 3'd7) begin
                            state_nxt = st_stop;
                        end else begin
                            n_nxt = n_q + 3'd1;
                        end
                    end else begin
                        s_nxt = s_q + 4'd1;
                    end
                end
            end
            default: begin
                tx_nxt = 1'b1;  // stop bit
                if (s_tick) begin
                    if (s_q == 4'd15) begin
                        state_nxt = st_idle;  // busy drops here
                    end else begin
                        s_nxt = s_q + 4'd1;
                    end
                end
            end
        endcase
    end

    // fsm control registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
            s_q     <= '0;
            n_q     <= '0;
            tx_q    <= 1'b1;  // line idle
        end else begin
            state_q <= state_nxt;
            s_q     <= s_nxt;
            n_q     <= n_nxt;
            tx_q    <= tx_nxt;
        end
    end

    always_ff @(posedge clk) begin
        din_q <= din_nxt;  // byte being sent
    end

    // bus side, busy register read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_rdata <= '0;
            o_ack   <= 1'b0;
        end else begin
            if (i_stb && !i_wr_en && i_addr == `SOC_UART_BUSY_ADDR) begin
                o_rdata <= {31'd0, busy};  // other reads keep last value
            end
            o_ack <= i_stb;
        end
    end

endmodule

//--- source/soc_top.sv
// soc peripheral top level

`timescale 1ns/1ps

module soc_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            i_stb,        // bus request, one cycle
    input  logic            i_wr_en,      // 1 write, 0 read
    input  soc_pkg::word_t  i_addr,
    input  soc_pkg::word_t  i_wdata,
    input  soc_pkg::bmask_t i_wr_mask,    // byte enables, ram only
    output soc_pkg::word_t  o_rdata,
    output logic            o_ack,
    output logic            o_uart_tx,    // serial out
    output logic            o_timer_irq,
    output logic            o_soft_irq
);
    import soc_pkg::*;

    logic  ram_stb, clint_stb, uart_stb;  // steered strobes
    logic  ram_ack, clint_ack, uart_ack;
    word_t ram_rdata;
    word_t clint_rdata;
    word_t uart_rdata;

    bus_decoder bus_decoder_i (
        .i_addr        (i_addr),
        .i_stb         (i_stb),
        .i_ram_rdata   (ram_rdata),
        .i_clint_rdata (clint_rdata),
        .i_uart_rdata  (uart_rdata),
        .i_ram_ack     (ram_ack),
        .i_clint_ack   (clint_ack),
        .i_uart_ack    (uart_ack),
        .o_ram_stb     (ram_stb),
        .o_clint_stb   (clint_stb),
        .o_uart_stb    (uart_stb),
        .o_rdata       (o_rdata),
        .o_ack         (o_ack)
    );

    data_ram data_ram_i (       // ram window
        .clk       (clk),
        .rst_n     (rst_n),
        .i_stb     (ram_stb),
        .i_wr_en   (i_wr_en),
        .i_addr    (i_addr),
        .i_wdata   (i_wdata),
        .i_wr_mask (i_wr_mask),
        .o_rdata   (ram_rdata),
        .o_ack     (ram_ack)
    );

    clint_timer clint_timer_i (  // clint window
        .clk         (clk),
        .rst_n       (rst_n),
        .i_stb       (clint_stb),
        .i_wr_en     (i_wr_en),
        .i_addr      (i_addr),
        .i_wdata     (i_wdata),
        .o_rdata     (clint_rdata),
        .o_ack       (clint_ack),
        .o_timer_irq (o_timer_irq),
        .o_soft_irq  (o_soft_irq)
    );

    uart_tx uart_tx_i (          // uart window
        .clk     (clk),
        .rst_n   (rst_n),
        .i_stb   (uart_stb),
        .i_wr_en (i_wr_en),
        .i_addr  (i_addr),
        .i_wdata (i_wdata),
        .o_rdata (uart_rdata),
        .o_ack   (uart_ack),
        .o_tx    (o_uart_tx)
    );

endmodule

//--- tests/soc_asserts.sv
// bus and interrupt checks

`timescale 1ns/1ps
`include "soc_params.svh"

module soc_asserts (
    input logic           clk,
    input logic           rst_n,
    input logic           i_stb,        // master strobe
    input logic           i_wr_en,
    input soc_pkg::word_t i_addr,
    input soc_pkg::word_t i_wdata,
    input logic           i_ack,        // top-level o_ack
    input logic           i_timer_irq,
    input logic           i_soft_irq,
    input logic           i_tick        // clint mtime step
);
    int   ack_fails  = 0;  // failures per property
    int   spur_fails = 0;
    int   soft_fails = 0;
    int   irq_fails  = 0;
    logic msip_last;       // last msip value written
    logic clint_wr;        // any write into the clint window

    assign clint_wr = i_stb && i_wr_en && i_addr > `SOC_RAM_LAST && i_addr <= `SOC_CLINT_LAST;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            msip_last <= 1'b0;
        end else if (i_stb && i_wr_en && i_addr == `SOC_MSIP_ADDR) begin
            msip_last <= i_wdata[0];  // bit 0 only
        end
    end

    // mapped strobe gets its ack one cycle later
    ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
        i_stb && i_addr <= `SOC_UART_LAST |=> i_ack)
        else begin
            ack_fails++;
            $error("no o_ack one cycle after a strobe to a mapped address");
        end

    // no ack out of nowhere
    ack_has_stb: assert property (@(posedge clk) disable iff (!rst_n)
        i_ack |-> $past(i_stb))
        else begin
            spur_fails++;
            $error("o_ack high without a strobe in the previous cycle");
        end

    soft_follows_msip: assert property (@(posedge clk) disable iff (!rst_n)
        i_soft_irq == msip_last)
        else begin
            soft_fails++;
            $error("o_soft_irq differs from the last msip write");
        end

    // irq moves only on a clint write or an mtime step
    timer_irq_cause: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(i_timer_irq) |-> $past(clint_wr || i_tick))
        else begin
            irq_fails++;
            $error("o_timer_irq changed without a clint write or timer tick");
        end

endmodule

bind soc_top soc_asserts soc_asserts_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_stb       (i_stb),
    .i_wr_en     (i_wr_en),
    .i_addr      (i_addr),
    .i_wdata     (i_wdata),
    .i_ack       (o_ack),
    .i_timer_irq (o_timer_irq),
    .i_soft_irq  (o_soft_irq),
    .i_tick      (clint_timer_i.tick)
);

//--- tests/tb_soc.sv
// soc peripheral testbench

`timescale 1ns/1ps
`include "soc_params.svh"

module tb_soc;
    import soc_pkg::*;

    localparam int ACK_LIMIT  = 8;                            // cycles allowed for o_ack
    localparam int MTIME_WAIT = 3 * (`SOC_TICK_CYCLES + 1);
    localparam int BIT_CLKS   = 16 * `SOC_UART_DVSR;          // clocks per uart bit

    logic   clk = 1'b0;
    logic   rst_n;
    logic   i_stb;
    logic   i_wr_en;
    word_t  i_addr;
    word_t  i_wdata;
    bmask_t i_wr_mask;
    word_t  o_rdata;
    logic   o_ack;
    logic   o_uart_tx;
    logic   o_timer_irq;
    logic   o_soft_irq;
    int     err_cnt   = 0;  // failed immediate checks
    int     test_base = 0;  // error total at test start
    int     tests_bad = 0;
    int     cyc       = 0;  // posedge count

    soc_top soc_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_stb       (i_stb),
        .i_wr_en     (i_wr_en),
        .i_addr      (i_addr),
        .i_wdata     (i_wdata),
        .i_wr_mask   (i_wr_mask),
        .o_rdata     (o_rdata),
        .o_ack       (o_ack),
        .o_uart_tx   (o_uart_tx),
        .o_timer_irq (o_timer_irq),
        .o_soft_irq  (o_soft_irq)
    );

    always #20 clk = ~clk;  // 40 ns period

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic int bound_fails();
        return soc_top_i.soc_asserts_i.ack_fails + soc_top_i.soc_asserts_i.spur_fails
            + soc_top_i.soc_asserts_i.soft_fails + soc_top_i.soc_asserts_i.irq_fails;
    endfunction

    task automatic abort_run(input string why);
        $display("timeout: %s", why);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    // strobe for one cycle then wait for ack
    task automatic transfer(input logic wr, input word_t addr, input word_t data,
                            input bmask_t mask, output word_t rdata);
        int n;
        @(negedge clk);
        i_addr    = addr;
        i_wdata   = data;
        i_wr_mask = mask;
        i_wr_en   = wr;
        i_stb     = 1'b1;
        @(negedge clk);
        i_stb = 1'b0;  // address held until next request
        n = 0;
        while (o_ack !== 1'b1 && n < ACK_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (o_ack !== 1'b1) begin
            abort_run($sformatf("no o_ack for address %h", addr));
        end else begin
            rdata = o_rdata;  // valid in ack cycle
        end
    endtask

    task automatic write_word(input word_t addr, input word_t data, input bmask_t mask);
        word_t unused;
        transfer(1'b1, addr, data, mask, unused);
    endtask

    task automatic read_word(input word_t addr, output word_t data);
        transfer(1'b0, addr, 32'd0, 4'h0, data);
    endtask

    task automatic wait_until_cycle(input int target);
        int n;
        n = 0;
        while (cyc < target && n < 1000) begin
            @(negedge clk);
            n++;
        end
        if (cyc < target) begin
            abort_run($sformatf("cycle %0d not reached", target));
        end
    endtask

    task automatic end_test(input string name);
        int now_errs;
        now_errs = err_cnt + bound_fails();
        if (now_errs == test_base) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, now_errs - test_base);
            tests_bad++;
        end
        test_base = now_errs;
    endtask

    initial begin
        word_t      addr, d_old, d_new, exp, rd, t0;
        bmask_t     mask;
        logic [9:0] frame;   // stop, byte, start
        int         n, edge_cyc;
        void'($urandom(32'h4f0cc74a));
        rst_n     = 1'b0;
        i_stb     = 1'b0;
        i_wr_en   = 1'b0;
        i_addr    = 32'd0;
        i_wdata   = 32'd0;
        i_wr_mask = 4'h0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        addr  = ($urandom % 2000) * 4;  // word aligned inside ram
        d_old = $urandom;
        d_new = $urandom;
        mask  = 4'(1 + $urandom % 14);  // partial and never empty
        write_word(addr, d_old, 4'hf);
        write_word(addr, d_new, mask);
        for (int b = 0; b < 4; b++) begin
            exp[8*b +: 8] = mask[b] ? d_new[8*b +: 8] : d_old[8*b +: 8];
        end
        read_word(addr, rd);
        check_word("o_rdata ram word", rd, exp);
        end_test("ram byte mask");

        write_word(`SOC_MTIME_ADDR + 4, 32'd0, 4'hf);  // high half first
        write_word(`SOC_MTIME_ADDR, 32'd0, 4'hf);
        write_word(`SOC_MTIMECMP_ADDR, 32'd5, 4'hf);
        write_word(`SOC_MTIMECMP_ADDR + 4, 32'd0, 4'hf);
        read_word(`SOC_MTIMECMP_ADDR, rd);
        check_word("o_rdata mtimecmp low", rd, 32'd5);
        read_word(`SOC_MTIMECMP_ADDR + 4, rd);
        check_word("o_rdata mtimecmp high", rd, 32'd0);
        n = 0;
        while (o_timer_irq !== 1'b1 && n < 400) begin
            @(negedge clk);
            n++;
        end
        assert (o_timer_irq === 1'b1) else begin
            $display("o_timer_irq did not rise within 400 cycles of mtimecmp = 5");
            err_cnt++;
        end
        write_word(`SOC_MTIMECMP_ADDR, 32'hffff_ffff, 4'hf);
        write_word(`SOC_MTIMECMP_ADDR + 4, 32'hffff_ffff, 4'hf);
        check_word("o_timer_irq", 32'(o_timer_irq), 32'd0);
        end_test("timer compare");

        read_word(`SOC_MTIME_ADDR, t0);
        wait_until_cycle(cyc + MTIME_WAIT);  // about three steps
        read_word(`SOC_MTIME_ADDR, rd);
        assert (rd - t0 >= 2 && rd - t0 <= 4) else begin
            $display("MISMATCH mtime delta got %h expected 00000002 to 00000004", rd - t0);
            err_cnt++;
        end
        end_test("mtime advance");

        write_word(`SOC_MSIP_ADDR, 32'd1, 4'hf);
        check_word("o_soft_irq", 32'(o_soft_irq), 32'd1);
        read_word(`SOC_MSIP_ADDR, rd);
        check_word("o_rdata msip", rd, 32'd1);
        write_word(`SOC_MSIP_ADDR, 32'd0, 4'hf);
        check_word("o_soft_irq", 32'(o_soft_irq), 32'd0);
        read_word(`SOC_MSIP_ADDR, rd);
        check_word("o_rdata msip", rd, 32'd0);
        end_test("software interrupt");

        frame = {1'b1, 8'($urandom), 1'b0};
        write_word(`SOC_UART_DATA_ADDR, {24'd0, frame[8:1]}, 4'hf);
        n = 0;
        while (o_uart_tx !== 1'b0 && n < 4 * BIT_CLKS) begin  // start bit edge
            @(negedge clk);
            n++;
        end
        assert (o_uart_tx === 1'b0) else begin
            $display("no start bit seen on o_uart_tx after the data write");
            err_cnt++;
        end
        edge_cyc = cyc;
        read_word(`SOC_UART_BUSY_ADDR, rd);
        check_word("o_rdata uart busy", rd, 32'd1);
        for (int k = 0; k < 10; k++) begin
            wait_until_cycle(edge_cyc + BIT_CLKS / 2 + k * BIT_CLKS);  // bit centre
            check_word($sformatf("o_uart_tx bit %0d", k), 32'(o_uart_tx), 32'(frame[k]));
        end
        n  = 0;
        rd = 32'd1;
        while (rd !== 32'd0 && n < 40) begin  // poll until frame done
            read_word(`SOC_UART_BUSY_ADDR, rd);
            n++;
        end
        check_word("o_rdata uart busy", rd, 32'd0);
        end_test("uart frame");

        $display("tests 5, failed %0d, check errors %0d, assertion errors %0d",
                 tests_bad, err_cnt, bound_fails());
        if (err_cnt + bound_fails() == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+source
source/soc_pkg.sv
source/bus_decoder.sv
source/data_ram.sv
source/clint_timer.sv
source/uart_tx.sv
source/soc_top.sv
tests/soc_asserts.sv
tests/tb_soc.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module tb_soc -o tb_soc
status=0
./obj_dir/tb_soc +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log
if grep -qF '** PASS **' sim.log; then
    exit 0
fi
echo "simulation failed, exit status $status"
exit 1
